//--- reservation_station.f
rs_pkg.sv
rs_bank.sv
rs_issue_arbiter.sv
reservation_station.sv
tb_reservation_station.sv

//--- run_sim.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -f reservation_station.f --top-module tb_reservation_station \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/Vtb_reservation_station > sim.log 2>&1 \
    ; cat sim.log
grep -q "Result: PASSED" sim.log && echo "simulation ok" && exit 0 \
    || { echo "simulation reported failure"; exit 1; }

//--- tb_reservation_station.sv
module tb_reservation_station;

    localparam int clock_period = 10;
    localparam int reset_cycles = 16;

    // cycle budget of each test summed for the watchdog
    localparam int alloc_cycles    = 12;
    localparam int wakeup_cycles   = 40;
    localparam int priority_cycles = 70;
    localparam int free_cycles     = 100;
    localparam int margin_cycles   = 50;
    localparam int watchdog_cycles = reset_cycles + 2 + alloc_cycles + wakeup_cycles
                                     + priority_cycles + free_cycles + margin_cycles;

    logic                         clock;
    logic                         rst_n;
    logic                         allocate;
    logic                         update;
    logic                         issue_enable;
    logic                         ls_issue_enable;
    logic                         rollback;
    logic                         done;
    rs_pkg::is_packet_t           input_packet;
    rs_pkg::is_packet_t           issued_packet;
    rs_pkg::preg_t                ready_reg;
    logic [rs_pkg::rob_idx_w-1:0] rob_head_index;
    rs_pkg::class_flags_t         entries_full;
    logic [2:0]                   free_alu;
    logic [1:0]                   free_mult;
    logic [1:0]                   free_load;
    logic [1:0]                   free_store;
    logic [1:0]                   free_branch;

    logic [31:0] lcg_state = 32'd32;
    int          errors;
    int          test_errors;
    int          tests_run;
    int          tests_failed;

    reservation_station dut_i (
        .clock           (clock),
        .rst_n           (rst_n),
        .allocate        (allocate),
        .input_packet    (input_packet),
        .done            (done),
        .update          (update),
        .ready_reg       (ready_reg),
        .issue_enable    (issue_enable),
        .ls_issue_enable (ls_issue_enable),
        .issued_packet   (issued_packet),
        .rob_head_index  (rob_head_index),
        .entries_full    (entries_full),
        .free_alu        (free_alu),
        .free_mult       (free_mult),
        .free_load       (free_load),
        .free_store      (free_store),
        .free_branch     (free_branch),
        .rollback        (rollback)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [5:0] random_tag();
        return 6'(lcg_next() >> 16);
    endfunction

    // fresh packet with pc and inst from the lcg
    function automatic rs_pkg::is_packet_t make_packet(
        input rs_pkg::fu_class_t cls, input logic [4:0] rob,
        input logic [5:0] src1, input logic ready1,
        input logic [5:0] src2, input logic ready2);
        rs_pkg::is_packet_t p;
        p = '0;
        p.valid = 1'b1;
        p.pc = lcg_next() & 32'hffff_fffc;
        p.inst = lcg_next();
        p.fu_class = cls;
        p.rob_index = rob;
        p.dest_reg.reg_num = random_tag();
        p.src1_reg = '{reg_num: src1, ready: ready1};
        p.src2_reg = '{reg_num: src2, ready: ready2};
        return p;
    endfunction

    task automatic begin_test();
        test_errors = 0;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, test_errors);
        end
    endtask

    task automatic report_mismatch(input string name, input string what,
                                   input string expected, input string actual);
        errors++;
        test_errors++;
        $display("Fail %s: %s expected %s actual %s", name, what, expected, actual);
    endtask

    task automatic report_problem(input string name, input string msg);
        errors++;
        test_errors++;
        $display("Fail %s: %s", name, msg);
    endtask

    // called at a falling edge and returns done for this request
    task automatic alloc_one(input rs_pkg::is_packet_t p, output logic got_done);
        allocate = 1'b1;
        input_packet = p;
        @(negedge clock);
        got_done = done;
        allocate = 1'b0;
    endtask

    task automatic clear_banks();
        rollback = 1'b1;
        @(negedge clock);
        rollback = 1'b0;
    endtask

    task automatic broadcast_tag(input logic [5:0] tag);
        update = 1'b1;
        ready_reg = '{reg_num: tag, ready: 1'b1};
        @(negedge clock);
        update = 1'b0;
    endtask

    task automatic expect_no_issue(input string name, input int cycles);
        repeat (cycles) begin
            @(negedge clock);
            if (issued_packet.valid !== 1'b0) begin
                report_problem(name, $sformatf("unexpected issue of pc %h", issued_packet.pc));
            end
        end
    endtask

    task automatic expect_issue(input string name, input rs_pkg::is_packet_t expected,
                                input int limit);
        int  i;
        logic found;
        found = 1'b0;
        for (i = 0; i < limit && !found; i++) begin
            @(negedge clock);
            if (issued_packet.valid === 1'b1) begin
                found = 1'b1;
                if (issued_packet !== expected) begin
                    report_mismatch(name, "issued_packet", $sformatf("%h", expected),
                                    $sformatf("%h", issued_packet));
                end
            end
        end
        if (!found) begin
            report_problem(name, $sformatf("packet with pc %h did not issue within %0d cycles",
                                           expected.pc, limit));
        end
    endtask

    task automatic test_reset_state();
        string name;
        name = "reset_state";
        begin_test();
        if (done !== 1'b0) report_mismatch(name, "done", "0", $sformatf("%b", done));
        if (issued_packet.valid !== 1'b0) begin
            report_mismatch(name, "issued valid", "0", $sformatf("%b", issued_packet.valid));
        end
        if (entries_full !== 5'b0) begin
            report_mismatch(name, "entries_full", "00000", $sformatf("%b", entries_full));
        end
        end_test(name);
    endtask

    task automatic test_alloc_full();
        string                name;
        rs_pkg::class_flags_t exp_full;
        logic                 got;
        int                   i;
        name = "alloc_full";
        begin_test();
        for (i = 0; i < 3; i++) begin
            alloc_one(make_packet(rs_pkg::fu_alu, 5'(i), random_tag(), 1'b0,
                                  random_tag(), 1'b0), got);
            if (got !== 1'b1) report_mismatch(name, "done", "1", $sformatf("%b", got));
        end
        alloc_one(make_packet(rs_pkg::fu_alu, 5'd3, random_tag(), 1'b0,
                              random_tag(), 1'b0), got);
        if (got !== 1'b0) report_mismatch(name, "done when full", "0", $sformatf("%b", got));
        exp_full = '0;
        exp_full.alu = 1'b1;
        if (entries_full !== exp_full) begin
            report_mismatch(name, "entries_full", $sformatf("%b", exp_full),
                            $sformatf("%b", entries_full));
        end
        clear_banks();
        end_test(name);
    endtask

    task automatic test_wakeup_issue();
        string              name;
        rs_pkg::is_packet_t blocker;
        rs_pkg::is_packet_t p;
        rs_pkg::is_packet_t expected;
        logic [5:0]         tag;
        logic               got;
        name = "wakeup_issue";
        begin_test();
        tag = random_tag();
        // parked in entry 0 on a tag that is never broadcast
        blocker = make_packet(rs_pkg::fu_alu, 5'd1, tag + 6'd1, 1'b0, tag + 6'd1, 1'b0);
        p = make_packet(rs_pkg::fu_alu, 5'd2, tag, 1'b0, tag + 6'd2, 1'b1);
        issue_enable = 1'b1;
        ls_issue_enable = 1'b1;
        alloc_one(blocker, got);
        if (got !== 1'b1) report_mismatch(name, "done", "1", $sformatf("%b", got));
        alloc_one(p, got);
        if (got !== 1'b1) report_mismatch(name, "done", "1", $sformatf("%b", got));
        expect_no_issue(name, 4);
        broadcast_tag(tag);
        if (issued_packet.valid !== 1'b0) begin
            report_problem(name, "packet issued on the edge of its own wakeup");
        end
        // lands in entry 1 with src1 now ready
        expected = p;
        expected.src1_reg.ready = 1'b1;
        expected.issued_fu_index = 3'd1;
        expect_issue(name, expected, 6);
        expect_no_issue(name, 6);
        clear_banks();
        issue_enable = 1'b0;
        end_test(name);
    endtask

    task automatic test_priority();
        string              name;
        rs_pkg::is_packet_t alu_p;
        rs_pkg::is_packet_t load_p;
        rs_pkg::is_packet_t store_p;
        rs_pkg::is_packet_t branch_p;
        logic [4:0]         rob;
        logic               got;
        name = "priority";
        begin_test();
        issue_enable = 1'b0;
        ls_issue_enable = 1'b0;
        alu_p = make_packet(rs_pkg::fu_alu, 5'd4, random_tag(), 1'b1, random_tag(), 1'b1);
        load_p = make_packet(rs_pkg::fu_load, 5'd5, random_tag(), 1'b1, random_tag(), 1'b1);
        store_p = make_packet(rs_pkg::fu_store, 5'd6, random_tag(), 1'b1, random_tag(), 1'b1);
        alloc_one(alu_p, got);
        alloc_one(load_p, got);
        alloc_one(store_p, got);
        // alu competes with an eligible load and store
        issue_enable = 1'b1;
        ls_issue_enable = 1'b1;
        expect_issue(name, alu_p, 8);
        // load and store are gated
        ls_issue_enable = 1'b0;
        expect_no_issue(name, 5);
        ls_issue_enable = 1'b1;
        expect_issue(name, load_p, 8);
        expect_issue(name, store_p, 8);
        rob = 5'(lcg_next() >> 20);
        rob_head_index = rob + 5'd1;
        branch_p = make_packet(rs_pkg::fu_branch, rob, random_tag(), 1'b1, random_tag(), 1'b1);
        alloc_one(branch_p, got);
        if (got !== 1'b1) report_mismatch(name, "branch done", "1", $sformatf("%b", got));
        expect_no_issue(name, 5);
        rob_head_index = rob;
        expect_issue(name, branch_p, 8);
        clear_banks();
        issue_enable = 1'b0;
        ls_issue_enable = 1'b0;
        end_test(name);
    endtask

    task automatic test_free_rollback();
        string name;
        logic  got;
        int    i;
        name = "free_rollback";
        begin_test();
        for (i = 0; i < 3; i++) begin
            alloc_one(make_packet(rs_pkg::fu_alu, 5'(i), random_tag(), 1'b0,
                                  random_tag(), 1'b0), got);
        end
        if (entries_full.alu !== 1'b1) begin
            report_mismatch(name, "full.alu", "1", $sformatf("%b", entries_full.alu));
        end
        free_alu = 3'b001;
        @(negedge clock);
        free_alu = 3'b000;
        if (entries_full.alu !== 1'b0) begin
            report_mismatch(name, "full.alu after free", "0",
                            $sformatf("%b", entries_full.alu));
        end
        alloc_one(make_packet(rs_pkg::fu_alu, 5'd7, random_tag(), 1'b0,
                              random_tag(), 1'b0), got);
        if (got !== 1'b1) report_mismatch(name, "done after free", "1", $sformatf("%b", got));
        alloc_one(make_packet(rs_pkg::fu_mult, 5'd8, random_tag(), 1'b0,
                              random_tag(), 1'b0), got);
        alloc_one(make_packet(rs_pkg::fu_load, 5'd9, random_tag(), 1'b0,
                              random_tag(), 1'b0), got);
        alloc_one(make_packet(rs_pkg::fu_branch, 5'd10, random_tag(), 1'b0,
                              random_tag(), 1'b0), got);
        clear_banks();
        if (entries_full !== 5'b0) begin
            report_mismatch(name, "entries_full", "00000", $sformatf("%b", entries_full));
        end
        issue_enable = 1'b1;
        ls_issue_enable = 1'b1;
        rob_head_index = 5'd10;
        // broadcast every tag and expect nothing back
        for (i = 0; i < 64; i++) begin
            broadcast_tag(6'(i));
            if (issued_packet.valid !== 1'b0) begin
                report_problem(name, $sformatf("stale packet pc %h issued after rollback",
                                               issued_packet.pc));
            end
        end
        expect_no_issue(name, 3);
        issue_enable = 1'b0;
        end_test(name);
    endtask

    initial begin
        #(clock_period * watchdog_cycles);
        $display("watchdog expired after %0d cycles, run stopped", watchdog_cycles);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        rst_n = 1'b0;
        allocate = 1'b0;
        input_packet = '0;
        update = 1'b0;
        ready_reg = '0;
        issue_enable = 1'b0;
        ls_issue_enable = 1'b0;
        rob_head_index = '0;
        free_alu = '0;
        free_mult = '0;
        free_load = '0;
        free_store = '0;
        free_branch = '0;
        rollback = 1'b0;
        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
        @(negedge clock);
        test_reset_state();
        test_alloc_full();
        test_wakeup_issue();
        test_priority();
        test_free_rollback();
        $display("tests run: %0d, tests failed: %0d, errors: %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- reservation_station.sv
module reservation_station #(
    parameter int alu_depth    = 3,
    parameter int mult_depth   = 2,
    parameter int load_depth   = 2,
    parameter int store_depth  = 2,
    parameter int branch_depth = 2
) (
    input  logic                         clock,
    input  logic                         rst_n,

    input  logic                         allocate,
    input  rs_pkg::is_packet_t           input_packet,
    output logic                         done,

    input  logic                         update,
    input  rs_pkg::preg_t                ready_reg,

    input  logic                         issue_enable,
    input  logic                         ls_issue_enable,
    output rs_pkg::is_packet_t           issued_packet,

    input  logic [rs_pkg::rob_idx_w-1:0] rob_head_index,

    output rs_pkg::class_flags_t         entries_full,

    input  logic [alu_depth-1:0]         free_alu,
    input  logic [mult_depth-1:0]        free_mult,
    input  logic [load_depth-1:0]        free_load,
    input  logic [store_depth-1:0]       free_store,
    input  logic [branch_depth-1:0]      free_branch,

    input  logic                         rollback
);

    rs_pkg::class_flags_t alloc_sel;
    rs_pkg::class_flags_t issuable;
    rs_pkg::class_flags_t grant;
    rs_pkg::cdb_t         wakeup;

    rs_pkg::is_packet_t alu_candidate;
    rs_pkg::is_packet_t mult_candidate;
    rs_pkg::is_packet_t load_candidate;
    rs_pkg::is_packet_t store_candidate;
    rs_pkg::is_packet_t branch_candidate;

    // route the packet to its class bank if there is room
    // unknown classes fall through and never allocate
    always_comb begin
        alloc_sel = '0;
        if (allocate) begin
            case (input_packet.fu_class)
                rs_pkg::fu_alu:    alloc_sel.alu    = !entries_full.alu;
                rs_pkg::fu_mult:   alloc_sel.mult   = !entries_full.mult;
                rs_pkg::fu_load:   alloc_sel.load   = !entries_full.load;
                rs_pkg::fu_store:  alloc_sel.store  = !entries_full.store;
                rs_pkg::fu_branch: alloc_sel.branch = !entries_full.branch;
                default:           alloc_sel        = '0;
            endcase
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= |alloc_sel;
        end
    end

    // one cdb broadcast shared by every bank
    always_comb begin
        wakeup.valid   = update;
        wakeup.reg_num = ready_reg.reg_num;
    end

    rs_bank #(.depth(alu_depth), .head_ordered(1'b0)) alu_bank (
        .clock          (clock),
        .rst_n          (rst_n),
        .rollback       (rollback),
        .alloc_en       (alloc_sel.alu),
        .alloc_packet   (input_packet),
        .wakeup         (wakeup),
        .rob_head_index (rob_head_index),
        .grant          (grant.alu),
        .free_mask      (free_alu),
        .full           (entries_full.alu),
        .issuable       (issuable.alu),
        .candidate      (alu_candidate)
    );

    rs_bank #(.depth(mult_depth), .head_ordered(1'b0)) mult_bank (
        .clock          (clock),
        .rst_n          (rst_n),
        .rollback       (rollback),
        .alloc_en       (alloc_sel.mult),
        .alloc_packet   (input_packet),
        .wakeup         (wakeup),
        .rob_head_index (rob_head_index),
        .grant          (grant.mult),
        .free_mask      (free_mult),
        .full           (entries_full.mult),
        .issuable       (issuable.mult),
        .candidate      (mult_candidate)
    );

    rs_bank #(.depth(load_depth), .head_ordered(1'b0)) load_bank (
        .clock          (clock),
        .rst_n          (rst_n),
        .rollback       (rollback),
        .alloc_en       (alloc_sel.load),
        .alloc_packet   (input_packet),
        .wakeup         (wakeup),
        .rob_head_index (rob_head_index),
        .grant          (grant.load),
        .free_mask      (free_load),
        .full           (entries_full.load),
        .issuable       (issuable.load),
        .candidate      (load_candidate)
    );

    rs_bank #(.depth(store_depth), .head_ordered(1'b0)) store_bank (
        .clock          (clock),
        .rst_n          (rst_n),
        .rollback       (rollback),
        .alloc_en       (alloc_sel.store),
        .alloc_packet   (input_packet),
        .wakeup         (wakeup),
        .rob_head_index (rob_head_index),
        .grant          (grant.store),
        .free_mask      (free_store),
        .full           (entries_full.store),
        .issuable       (issuable.store),
        .candidate      (store_candidate)
    );

    // branches wait until they reach the rob head
    rs_bank #(.depth(branch_depth), .head_ordered(1'b1)) branch_bank (
        .clock          (clock),
        .rst_n          (rst_n),
        .rollback       (rollback),
        .alloc_en       (alloc_sel.branch),
        .alloc_packet   (input_packet),
        .wakeup         (wakeup),
        .rob_head_index (rob_head_index),
        .grant          (grant.branch),
        .free_mask      (free_branch),
        .full           (entries_full.branch),
        .issuable       (issuable.branch),
        .candidate      (branch_candidate)
    );

    rs_issue_arbiter issue_arbiter (
        .clock            (clock),
        .rst_n            (rst_n),
        .issue_enable     (issue_enable),
        .ls_issue_enable  (ls_issue_enable),
        .issuable         (issuable),
        .alu_candidate    (alu_candidate),
        .mult_candidate   (mult_candidate),
        .load_candidate   (load_candidate),
        .store_candidate  (store_candidate),
        .branch_candidate (branch_candidate),
        .grant            (grant),
        .issued_packet    (issued_packet)
    );

endmodule

//--- rs_issue_arbiter.sv
module rs_issue_arbiter (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 issue_enable,
    input  logic                 ls_issue_enable,
    input  rs_pkg::class_flags_t issuable,
    input  rs_pkg::is_packet_t   alu_candidate,
    input  rs_pkg::is_packet_t   mult_candidate,
    input  rs_pkg::is_packet_t   load_candidate,
    input  rs_pkg::is_packet_t   store_candidate,
    input  rs_pkg::is_packet_t   branch_candidate,
    output rs_pkg::class_flags_t grant,
    output rs_pkg::is_packet_t   issued_packet
);

    rs_pkg::is_packet_t next_packet;
    rs_pkg::is_packet_t issued_payload;
    logic               issued_valid;

    // fixed priority: alu, mult, load, store, branch
    always_comb begin
        grant = '0;
        if (issue_enable) begin
            if (issuable.alu) begin
                grant.alu = 1'b1;
            end else if (issuable.mult) begin
                grant.mult = 1'b1;
            end else if (ls_issue_enable && issuable.load) begin
                grant.load = 1'b1;
            end else if (ls_issue_enable && issuable.store) begin
                grant.store = 1'b1;
            end else if (issuable.branch) begin
                grant.branch = 1'b1;
            end
        end
    end

    // grant is one-hot, so a plain chain is enough
    always_comb begin
        next_packet = '0;
        if (grant.alu) begin
            next_packet = alu_candidate;
        end else if (grant.mult) begin
            next_packet = mult_candidate;
        end else if (grant.load) begin
            next_packet = load_candidate;
        end else if (grant.store) begin
            next_packet = store_candidate;
        end else if (grant.branch) begin
            next_packet = branch_candidate;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            issued_valid <= 1'b0;
        end else begin
            issued_valid <= next_packet.valid;
        end
    end

    always_ff @(posedge clock) begin
        issued_payload <= next_packet;
    end

    // valid bit comes from the reset flop
    always_comb begin
        issued_packet       = issued_payload;
        issued_packet.valid = issued_valid;
    end

endmodule

//--- rs_bank.sv
module rs_bank #(
    parameter int depth        = 2,
    parameter bit head_ordered = 1'b0
) (
    input  logic                            clock,
    input  logic                            rst_n,
    input  logic                            rollback,
    input  logic                            alloc_en,
    input  rs_pkg::is_packet_t              alloc_packet,
    input  rs_pkg::cdb_t                    wakeup,
    input  logic [rs_pkg::rob_idx_w-1:0]    rob_head_index,
    input  logic                            grant,
    input  logic [depth-1:0]                free_mask,
    output logic                            full,
    output logic                            issuable,
    output rs_pkg::is_packet_t              candidate
);

    localparam int idx_w = rs_pkg::fu_idx_w;

    // empty slot, issued set so it can never be picked
    localparam rs_pkg::rs_entry_t empty_entry = '{
        busy:   1'b0,
        issued: 1'b1,
        packet: '0
    };

    rs_pkg::rs_entry_t entries      [depth];
    rs_pkg::rs_entry_t entries_next [depth];

    logic [idx_w-1:0] free_idx;
    logic [idx_w-1:0] pick_idx;

    // lowest free slot, full when none is left
    always_comb begin
        free_idx = '0;
        full     = 1'b1;
        for (int i = depth - 1; i >= 0; i--) begin
            if (!entries[i].busy) begin
                free_idx = idx_w'(i);
                full     = 1'b0;
            end
        end
    end

    // highest ready slot wins
    always_comb begin
        issuable  = 1'b0;
        pick_idx  = '0;
        candidate = '0;
        for (int i = 0; i < depth; i++) begin
            if (!entries[i].issued
                    && entries[i].packet.src1_reg.ready
                    && entries[i].packet.src2_reg.ready
                    && (!head_ordered
                        || entries[i].packet.rob_index == rob_head_index)) begin
                issuable  = 1'b1;
                pick_idx  = idx_w'(i);
                candidate = entries[i].packet;
            end
        end
        // functional unit needs the slot number to free it later
        candidate.issued_fu_index = pick_idx;
    end

    // next slot state, later steps override earlier ones
    always_comb begin
        entries_next = entries;
        for (int i = 0; i < depth; i++) begin
            // tag match from the cdb
            if (wakeup.valid) begin
                if (entries[i].packet.src1_reg.reg_num == wakeup.reg_num) begin
                    entries_next[i].packet.src1_reg.ready = 1'b1;
                end
                if (entries[i].packet.src2_reg.reg_num == wakeup.reg_num) begin
                    entries_next[i].packet.src2_reg.ready = 1'b1;
                end
            end

            // arbiter took this one
            if (grant && pick_idx == idx_w'(i)) begin
                entries_next[i].issued = 1'b1;
            end

            // released by the functional unit
            if (free_mask[i]) begin
                entries_next[i].busy   = 1'b0;
                entries_next[i].issued = 1'b1;
            end

            // new packet replaces the whole slot, its own ready bits stay
            if (alloc_en && free_idx == idx_w'(i)) begin
                entries_next[i].busy   = 1'b1;
                entries_next[i].issued = 1'b0;
                entries_next[i].packet = alloc_packet;
            end

            if (rollback) begin
                entries_next[i] = empty_entry;
            end
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < depth; i++) begin
                entries[i] <= empty_entry;
            end
        end else begin
            entries <= entries_next;
        end
    end

endmodule

//--- rs_pkg.sv
package rs_pkg;

    // physical register tag
    localparam int preg_w = 6;

    // reorder buffer index
    localparam int rob_idx_w = 5;

    localparam int pc_w   = 32;
    localparam int inst_w = 32;

    // entry index inside one bank, banks of up to 8 entries
    localparam int fu_idx_w = 3;

    // functional unit class of a decoded instruction
    typedef enum logic [2:0] {
        fu_alu    = 3'd0,
        fu_mult   = 3'd1,
        fu_load   = 3'd2,
        fu_store  = 3'd3,
        fu_branch = 3'd4
    } fu_class_t;

    // physical register with its ready bit
    typedef struct packed {
        logic [preg_w-1:0] reg_num;
        logic              ready;
    } preg_t;

    // decode to issue packet
    typedef struct packed {
        logic                 valid;
        logic [pc_w-1:0]      pc;
        logic [inst_w-1:0]    inst;
        fu_class_t            fu_class;
        logic [rob_idx_w-1:0] rob_index;
        preg_t                dest_reg;
        preg_t                src1_reg;
        preg_t                src2_reg;
        logic [fu_idx_w-1:0]  issued_fu_index;
    } is_packet_t;

    // one reservation station slot
    typedef struct packed {
        logic       busy;
        logic       issued;
        is_packet_t packet;
    } rs_entry_t;

    // common data bus broadcast, one tag per cycle
    typedef struct packed {
        logic              valid;
        logic [preg_w-1:0] reg_num;
    } cdb_t;

    // one bit per class
    // used for full flags, issuable flags and grants
    typedef struct packed {
        logic alu;
        logic mult;
        logic load;
        logic store;
        logic branch;
    } class_flags_t;

endpackage
